// File: fifo_addr_pkg.sv
// shared widths, layer types and slot-bank constants for the FIFO base-address initializer
package fifo_addr_pkg;

    // global-buffer byte address
    typedef logic [31:0] addr_t;

    // tile size, output length or row counter
    typedef logic [31:0] count_t;

    // channel count of the current layer
    typedef logic [7:0] chan_t;

    // layer type as issued by the tile scheduler
    typedef enum logic [1:0] {
        LAYER_POINTWISE = 2'd0,
        LAYER_DEPTHWISE = 2'd1,
        LAYER_STANDARD  = 2'd2,
        LAYER_LINEAR    = 2'd3
    } layer_type_e;

    // base-address slots per FIFO group
    localparam int NUM_SLOTS = 32;

    // depthwise mapping: 3 rows for each of 10 channels
    // slots above DW_CHANNELS*DW_ROWS are left alone by a depthwise load
    localparam int DW_CHANNELS = 10;
    localparam int DW_ROWS = 3;

    // zero region, read in place of a padded top row
    localparam addr_t ZERO_ZONE = 32'h8000_0000;

endpackage

// File: fifo_init_ctrl.sv
// init strobe and layer-type decode into bank load strobes, FIFO resets and ipsum base select
`timescale 1ns/1ps

module fifo_init_ctrl
    import fifo_addr_pkg::*;
(
    // only used to sample the check below
    input  logic        clk,
    input  logic        rst_n,

    input  logic        init_i,
    input  layer_type_e layer_type_i,
    input  logic        is_bias_i,
    input  addr_t       ipsum_base_i,
    input  addr_t       bias_base_i,

    output logic        load_pw_o,
    output logic        load_dw_o,
    output addr_t       ipsum_sel_base_o,
    output logic        ifmap_fifo_reset_o,
    output logic        ipsum_fifo_reset_o,
    output logic        opsum_fifo_reset_o
);

    // all three FIFO groups are flushed for the whole init cycle
    assign ifmap_fifo_reset_o = init_i;
    assign ipsum_fifo_reset_o = init_i;
    assign opsum_fifo_reset_o = init_i;

    // standard and linear layers flush but load nothing
    always_comb begin
        load_pw_o = 1'b0;
        load_dw_o = 1'b0;
        if (init_i) begin
            case (layer_type_i)
                LAYER_POINTWISE: load_pw_o = 1'b1;
                LAYER_DEPTHWISE: load_dw_o = 1'b1;
                default: begin
                    load_pw_o = 1'b0;
                    load_dw_o = 1'b0;
                end
            endcase
        end
    end

    // first ipsum pass of a layer reads the bias region instead
    assign ipsum_sel_base_o = is_bias_i ? bias_base_i : ipsum_base_i;

    // banks rely on the two load modes being exclusive
    a_load_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_pw_o && load_dw_o)
    );

endmodule

// File: ifmap_addr_gen.sv
// ifmap FIFO base-address bank, pointwise channel layout or depthwise three-row sliding window
`timescale 1ns/1ps

module ifmap_addr_gen
    import fifo_addr_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    input  logic   load_pw_i,
    input  logic   load_dw_i,
    input  addr_t  base_i,
    input  count_t tile_n_i,
    input  chan_t  in_c_i,
    input  count_t row_cnt_i,
    input  logic   tile_first_i,

    output addr_t  slot_addr_o [NUM_SLOTS]
);

    // how a depthwise load fills each channel's three slots
    typedef enum logic [1:0] {
        WIN_PAD,    // zero row on top, then rows 0 and 1
        WIN_FRESH,  // rows 0 to 2
        WIN_SHIFT   // drop oldest row, fetch the next one
    } win_mode_e;

    addr_t     slot_q [NUM_SLOTS];
    addr_t     slot_d [NUM_SLOTS];
    addr_t     row_pitch;
    addr_t     chan_stride;
    addr_t     next_row_off;
    win_mode_e win_mode;

    // rows of one channel are interleaved in_C apart
    assign row_pitch    = addr_t'(in_c_i);
    assign chan_stride  = tile_n_i * row_pitch;
    assign next_row_off = (row_cnt_i + count_t'(1)) * row_pitch;

    always_comb begin
        if (row_cnt_i == '0) begin
            win_mode = tile_first_i ? WIN_PAD : WIN_FRESH;
        end else if (row_cnt_i == count_t'(1) && tile_first_i) begin
            // padded start has only two real rows so far
            win_mode = WIN_FRESH;
        end else begin
            win_mode = WIN_SHIFT;
        end
    end

    always_comb begin
        addr_t chan_base;

        slot_d    = slot_q;
        chan_base = '0;
        if (load_pw_i) begin
            // one input channel per slot, tile_n apart
            for (int k = 0; k < NUM_SLOTS; k++) begin
                slot_d[k] = base_i + addr_t'(k) * tile_n_i;
            end
        end else if (load_dw_i) begin
            for (int c = 0; c < DW_CHANNELS; c++) begin
                chan_base = base_i + addr_t'(c) * chan_stride;
                case (win_mode)
                    WIN_PAD: begin
                        slot_d[DW_ROWS*c]     = ZERO_ZONE;
                        slot_d[DW_ROWS*c + 1] = chan_base;
                        slot_d[DW_ROWS*c + 2] = chan_base + row_pitch;
                    end
                    WIN_FRESH: begin
                        slot_d[DW_ROWS*c]     = chan_base;
                        slot_d[DW_ROWS*c + 1] = chan_base + row_pitch;
                        slot_d[DW_ROWS*c + 2] = chan_base + 2 * row_pitch;
                    end
                    default: begin
                        // new bottom row keeps its channel offset
                        slot_d[DW_ROWS*c]     = slot_q[DW_ROWS*c + 1];
                        slot_d[DW_ROWS*c + 1] = slot_q[DW_ROWS*c + 2];
                        slot_d[DW_ROWS*c + 2] = chan_base + next_row_off;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_SLOTS; k++) begin
                slot_q[k] <= '0;
            end
        end else if (load_pw_i || load_dw_i) begin
            slot_q <= slot_d;
        end
    end

    assign slot_addr_o = slot_q;

    // zero channels would collapse every row onto the channel base
    a_dw_chan_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_dw_i |-> (in_c_i != '0)
    );

endmodule

// File: psum_addr_gen.sv
// partial-sum FIFO base-address bank, shared by the ipsum and opsum groups
`timescale 1ns/1ps

module psum_addr_gen
    import fifo_addr_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    input  logic   load_pw_i,
    input  logic   load_dw_i,
    input  addr_t  base_i,
    input  count_t pw_stride_i,
    input  count_t dw_chan_stride_i,
    input  chan_t  in_c_i,

    output addr_t  slot_addr_o [NUM_SLOTS]
);

    addr_t slot_q [NUM_SLOTS];
    addr_t slot_d [NUM_SLOTS];
    addr_t row_pitch;
    addr_t chan_stride;

    assign row_pitch   = addr_t'(in_c_i);
    // depthwise channel stride scaled by the interleave
    assign chan_stride = dw_chan_stride_i * row_pitch;

    always_comb begin
        addr_t chan_base;

        slot_d    = slot_q;
        chan_base = '0;
        if (load_pw_i) begin
            // one output channel per slot
            for (int k = 0; k < NUM_SLOTS; k++) begin
                slot_d[k] = base_i + addr_t'(k) * pw_stride_i;
            end
        end else if (load_dw_i) begin
            // all 10 channels, three rows each
            for (int c = 0; c < DW_CHANNELS; c++) begin
                chan_base = base_i + addr_t'(c) * chan_stride;
                for (int r = 0; r < DW_ROWS; r++) begin
                    slot_d[DW_ROWS*c + r] = chan_base + addr_t'(r) * row_pitch;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_SLOTS; k++) begin
                slot_q[k] <= '0;
            end
        end else if (load_pw_i || load_dw_i) begin
            slot_q <= slot_d;
        end
    end

    assign slot_addr_o = slot_q;

    // slots are only written on a load cycle
    for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_hold_chk
        a_slot_hold: assert property (
            @(posedge clk) disable iff (!rst_n)
            !(load_pw_i || load_dw_i) |=> $stable(slot_q[k])
        );
    end

endmodule

// File: fifo_addr_top.sv
// top of the FIFO base-address initializer, init decode plus ifmap, ipsum and opsum banks
`timescale 1ns/1ps

module fifo_addr_top
    import fifo_addr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        init_i,
    input  layer_type_e layer_type_i,
    input  logic        is_bias_i,

    input  addr_t       ifmap_base_i,
    input  addr_t       ipsum_base_i,
    input  addr_t       opsum_base_i,
    input  addr_t       bias_base_i,

    input  count_t      row_cnt_i,
    input  count_t      tile_n_i,
    input  count_t      on_real_i,
    input  chan_t       in_c_i,
    input  logic        tile_first_i,

    output addr_t       ifmap_slot_o [NUM_SLOTS],
    output addr_t       ipsum_slot_o [NUM_SLOTS],
    output addr_t       opsum_slot_o [NUM_SLOTS],

    output logic        ifmap_fifo_reset_o,
    output logic        ipsum_fifo_reset_o,
    output logic        opsum_fifo_reset_o
);

    logic  load_pw;
    logic  load_dw;
    addr_t ipsum_sel_base;

    fifo_init_ctrl u_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .init_i             (init_i),
        .layer_type_i       (layer_type_i),
        .is_bias_i          (is_bias_i),
        .ipsum_base_i       (ipsum_base_i),
        .bias_base_i        (bias_base_i),
        .load_pw_o          (load_pw),
        .load_dw_o          (load_dw),
        .ipsum_sel_base_o   (ipsum_sel_base),
        .ifmap_fifo_reset_o (ifmap_fifo_reset_o),
        .ipsum_fifo_reset_o (ipsum_fifo_reset_o),
        .opsum_fifo_reset_o (opsum_fifo_reset_o)
    );

    ifmap_addr_gen u_ifmap (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_pw_i    (load_pw),
        .load_dw_i    (load_dw),
        .base_i       (ifmap_base_i),
        .tile_n_i     (tile_n_i),
        .in_c_i       (in_c_i),
        .row_cnt_i    (row_cnt_i),
        .tile_first_i (tile_first_i),
        .slot_addr_o  (ifmap_slot_o)
    );

    // ipsum channels are laid out tile_n apart in depthwise mode
    psum_addr_gen u_ipsum (
        .clk              (clk),
        .rst_n            (rst_n),
        .load_pw_i        (load_pw),
        .load_dw_i        (load_dw),
        .base_i           (ipsum_sel_base),
        .pw_stride_i      (on_real_i),
        .dw_chan_stride_i (tile_n_i),
        .in_c_i           (in_c_i),
        .slot_addr_o      (ipsum_slot_o)
    );

    // opsum uses the real output length for both layouts
    psum_addr_gen u_opsum (
        .clk              (clk),
        .rst_n            (rst_n),
        .load_pw_i        (load_pw),
        .load_dw_i        (load_dw),
        .base_i           (opsum_base_i),
        .pw_stride_i      (on_real_i),
        .dw_chan_stride_i (on_real_i),
        .in_c_i           (in_c_i),
        .slot_addr_o      (opsum_slot_o)
    );

endmodule

// File: tb_fifo_addr_top.sv
// self-checking testbench for fifo_addr_top, applies a stimulus table and compares all 96 slots
`timescale 1ns/1ps

module tb_fifo_addr_top
    import fifo_addr_pkg::*;
;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_STEPS  = 12;

    logic        clk;
    logic        rst_n;
    logic        init;
    layer_type_e layer_type;
    logic        is_bias;
    addr_t       ifmap_base;
    addr_t       ipsum_base;
    addr_t       opsum_base;
    addr_t       bias_base;
    count_t      row_cnt;
    count_t      tile_n;
    count_t      on_real;
    chan_t       in_c;
    logic        tile_first;
    addr_t       ifmap_slot [NUM_SLOTS];
    addr_t       ipsum_slot [NUM_SLOTS];
    addr_t       opsum_slot [NUM_SLOTS];
    logic        ifmap_fifo_reset;
    logic        ipsum_fifo_reset;
    logic        opsum_fifo_reset;

    // stimulus table, one entry per step
    logic        tbl_init [NUM_STEPS];
    layer_type_e tbl_layer [NUM_STEPS];
    logic        tbl_bias [NUM_STEPS];
    logic        tbl_first [NUM_STEPS];
    count_t      tbl_row [NUM_STEPS];
    count_t      tbl_tile_n [NUM_STEPS];
    chan_t       tbl_in_c [NUM_STEPS];
    count_t      tbl_on_real [NUM_STEPS];

    // expected slot contents
    addr_t       ifmap_exp [NUM_SLOTS];
    addr_t       ipsum_exp [NUM_SLOTS];
    addr_t       opsum_exp [NUM_SLOTS];

    logic [31:0] seed;
    int          slot_errors;
    int          reset_errors;

    fifo_addr_top uut (
        .clk                (clk),
        .rst_n              (rst_n),
        .init_i             (init),
        .layer_type_i       (layer_type),
        .is_bias_i          (is_bias),
        .ifmap_base_i       (ifmap_base),
        .ipsum_base_i       (ipsum_base),
        .opsum_base_i       (opsum_base),
        .bias_base_i        (bias_base),
        .row_cnt_i          (row_cnt),
        .tile_n_i           (tile_n),
        .on_real_i          (on_real),
        .in_c_i             (in_c),
        .tile_first_i       (tile_first),
        .ifmap_slot_o       (ifmap_slot),
        .ipsum_slot_o       (ipsum_slot),
        .opsum_slot_o       (opsum_slot),
        .ifmap_fifo_reset_o (ifmap_fifo_reset),
        .ipsum_fifo_reset_o (ipsum_fifo_reset),
        .opsum_fifo_reset_o (opsum_fifo_reset)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // address of window row r of depthwise channel c
    function automatic addr_t dw_row_addr(addr_t base, int c, count_t r, count_t tn, chan_t ic);
        addr_t ic_w;

        ic_w = addr_t'(ic);
        return base + addr_t'(c) * tn * ic_w + r * ic_w;
    endfunction

    task automatic set_step(input int idx, input logic ini, input layer_type_e lt,
                            input logic bias, input logic first, input count_t row,
                            input count_t tn, input chan_t ic, input count_t onr);
        tbl_init[idx]    = ini;
        tbl_layer[idx]   = lt;
        tbl_bias[idx]    = bias;
        tbl_first[idx]   = first;
        tbl_row[idx]     = row;
        tbl_tile_n[idx]  = tn;
        tbl_in_c[idx]    = ic;
        tbl_on_real[idx] = onr;
    endtask

    task automatic fill_table();
        // pointwise load, hold with init low, then bias select
        set_step(0, 1'b1, LAYER_POINTWISE, 1'b0, 1'b0, 0, 64, 4, 48);
        set_step(1, 1'b0, LAYER_POINTWISE, 1'b0, 1'b0, 0, 80, 2, 24);
        set_step(2, 1'b1, LAYER_POINTWISE, 1'b1, 1'b0, 0, 100, 3, 36);
        // depthwise first tile, padded start then sliding
        set_step(3, 1'b1, LAYER_DEPTHWISE, 1'b0, 1'b1, 0, 16, 8, 12);
        set_step(4, 1'b1, LAYER_DEPTHWISE, 1'b0, 1'b1, 1, 16, 8, 12);
        set_step(5, 1'b1, LAYER_DEPTHWISE, 1'b0, 1'b1, 2, 16, 8, 12);
        set_step(6, 1'b1, LAYER_DEPTHWISE, 1'b0, 1'b1, 3, 16, 8, 12);
        // depthwise later tile
        set_step(7, 1'b1, LAYER_DEPTHWISE, 1'b1, 1'b0, 0, 20, 6, 14);
        set_step(8, 1'b1, LAYER_DEPTHWISE, 1'b1, 1'b0, 1, 20, 6, 14);
        set_step(9, 1'b1, LAYER_DEPTHWISE, 1'b1, 1'b0, 2, 20, 6, 14);
        // flush only, nothing loaded
        set_step(10, 1'b1, LAYER_STANDARD, 1'b0, 1'b0, 0, 30, 5, 9);
        set_step(11, 1'b1, LAYER_LINEAR, 1'b0, 1'b0, 0, 40, 7, 11);
    endtask

    task automatic update_model(input int i);
        addr_t  old_if [NUM_SLOTS];
        addr_t  ip_base;
        count_t r;

        old_if  = ifmap_exp;
        ip_base = tbl_bias[i] ? bias_base : ipsum_base;
        r       = tbl_row[i];
        if (tbl_init[i] && tbl_layer[i] == LAYER_POINTWISE) begin
            for (int k = 0; k < NUM_SLOTS; k++) begin
                ifmap_exp[k] = ifmap_base + addr_t'(k) * tbl_tile_n[i];
                ipsum_exp[k] = ip_base + addr_t'(k) * tbl_on_real[i];
                opsum_exp[k] = opsum_base + addr_t'(k) * tbl_on_real[i];
            end
        end else if (tbl_init[i] && tbl_layer[i] == LAYER_DEPTHWISE) begin
            for (int c = 0; c < DW_CHANNELS; c++) begin
                for (int rr = 0; rr < DW_ROWS; rr++) begin
                    ipsum_exp[3*c+rr] = dw_row_addr(ip_base, c, rr, tbl_tile_n[i], tbl_in_c[i]);
                    opsum_exp[3*c+rr] = dw_row_addr(opsum_base, c, rr, tbl_on_real[i],
                                                    tbl_in_c[i]);
                end
                if (r == 0 && tbl_first[i]) begin
                    ifmap_exp[3*c]   = ZERO_ZONE;
                    ifmap_exp[3*c+1] = dw_row_addr(ifmap_base, c, 0, tbl_tile_n[i], tbl_in_c[i]);
                    ifmap_exp[3*c+2] = dw_row_addr(ifmap_base, c, 1, tbl_tile_n[i], tbl_in_c[i]);
                end else if (r == 0 || (r == 1 && tbl_first[i])) begin
                    for (int rr = 0; rr < DW_ROWS; rr++) begin
                        ifmap_exp[3*c+rr] = dw_row_addr(ifmap_base, c, rr, tbl_tile_n[i],
                                                        tbl_in_c[i]);
                    end
                end else begin
                    ifmap_exp[3*c]   = old_if[3*c+1];
                    ifmap_exp[3*c+1] = old_if[3*c+2];
                    ifmap_exp[3*c+2] = dw_row_addr(ifmap_base, c, r + 1, tbl_tile_n[i],
                                                   tbl_in_c[i]);
                end
            end
        end
    endtask

    task automatic compare_slot(input string name, input int step, input int k,
                                input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("[FAIL] step %0d %s[%0d]: expected %h, got %h", step, name, k, exp, act);
            slot_errors++;
        end
    endtask

    task automatic check_slots(input int step);
        for (int k = 0; k < NUM_SLOTS; k++) begin
            compare_slot("ifmap_slot_o", step, k, ifmap_exp[k], ifmap_slot[k]);
            compare_slot("ipsum_slot_o", step, k, ipsum_exp[k], ipsum_slot[k]);
            compare_slot("opsum_slot_o", step, k, opsum_exp[k], opsum_slot[k]);
        end
    endtask

    task automatic check_resets(input logic exp);
        if ({ifmap_fifo_reset, ipsum_fifo_reset, opsum_fifo_reset} !== {3{exp}}) begin
            $display("[FAIL] fifo_reset_o (ifmap,ipsum,opsum): expected %h, got %h",
                     {3{exp}}, {ifmap_fifo_reset, ipsum_fifo_reset, opsum_fifo_reset});
            reset_errors++;
        end
    endtask

    // watchdog, four clock periods per table entry plus margin
    initial begin
        #((NUM_STEPS + 10) * 4 * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        init         = 1'b0;
        layer_type   = LAYER_POINTWISE;
        is_bias      = 1'b0;
        ifmap_base   = '0;
        ipsum_base   = '0;
        opsum_base   = '0;
        bias_base    = '0;
        row_cnt      = '0;
        tile_n       = '0;
        on_real      = '0;
        in_c         = 8'd1;
        tile_first   = 1'b0;
        seed         = 32'd4;
        slot_errors  = 0;
        reset_errors = 0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            ifmap_exp[k] = '0;
            ipsum_exp[k] = '0;
            opsum_exp[k] = '0;
        end
        fill_table();

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_resets(1'b0);
        check_slots(-1);

        for (int i = 0; i < NUM_STEPS; i++) begin
            @(posedge clk);
            // new bases at the start of each layer or tile
            if (tbl_layer[i] != LAYER_DEPTHWISE || tbl_row[i] == 0) begin
                seed       = lcg_next(seed);
                ifmap_base <= seed & 32'h0FFF_FFF0;
                seed       = lcg_next(seed);
                ipsum_base <= seed & 32'h0FFF_FFF0;
                seed       = lcg_next(seed);
                opsum_base <= seed & 32'h0FFF_FFF0;
                seed       = lcg_next(seed);
                bias_base  <= seed & 32'h0FFF_FFF0;
            end
            init       <= tbl_init[i];
            layer_type <= tbl_layer[i];
            is_bias    <= tbl_bias[i];
            tile_first <= tbl_first[i];
            row_cnt    <= tbl_row[i];
            tile_n     <= tbl_tile_n[i];
            in_c       <= tbl_in_c[i];
            on_real    <= tbl_on_real[i];
            @(negedge clk);
            check_resets(tbl_init[i]);
            @(posedge clk);
            init <= 1'b0;
            update_model(i);
            @(negedge clk);
            check_resets(1'b0);
            check_slots(i);
        end

        $display("errors: slot %0d, fifo reset %0d, total %0d",
                 slot_errors, reset_errors, slot_errors + reset_errors);
        if (slot_errors + reset_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: all.f
fifo_addr_pkg.sv
fifo_init_ctrl.sv
ifmap_addr_gen.sv
psum_addr_gen.sv
fifo_addr_top.sv
tb_fifo_addr_top.sv

// File: Bender.yml
package:
  name: fifo_addr

dependencies: {}

sources:
  # shared package first
  - fifo_addr_pkg.sv
  # design
  - fifo_init_ctrl.sv
  - ifmap_addr_gen.sv
  - psum_addr_gen.sv
  - fifo_addr_top.sv
  # testbench
  - target: test
    files:
      - tb_fifo_addr_top.sv
